// ==== verilog/hexDisplayPkg.sv ====
package hexDisplayPkg;

  localparam int NumDigits = 8;                 // Digits on the display board
  localparam int ScanTicks = 250;               // Last count of the per-digit scan period
  localparam int AddrW     = 6;                 // Byte address width of the register port
  localparam int DataW     = 32;                // Width of the bus data words

  localparam logic [AddrW-1:0] AddrDigitBase = 6'h00; // Digit i sits at base + 4*i
  localparam logic [AddrW-1:0] AddrBulk      = 6'h20; // All eight values as packed nibbles
  localparam logic [AddrW-1:0] AddrMask      = 6'h24; // All eight lit flags in bits 7..0

  typedef struct packed {
    logic       lit;                            // Digit is shown only when this is set
    logic [3:0] value;                          // Hex value from 0 to F
  } digitCode_t;

  typedef digitCode_t [NumDigits-1:0] hexDigits_t; // Digit 0 is the rightmost one

  typedef enum logic [1:0] {
    RdNone,                                     // Unmapped address, reads back as zero
    RdDigit,                                    // One digit code, zero-extended
    RdBulk,                                     // Eight packed values
    RdMask                                      // Eight lit flags
  } rdKind_t;

  typedef union packed {
    struct packed {
      logic [DataW-$bits(digitCode_t)-1:0] unused; // Ignored by single-digit writes
      digitCode_t                          code;   // Lit flag and value of one digit
    } single;
    logic [NumDigits-1:0][3:0] bulk;            // Nibble i carries the value of digit i
  } hexWord_u;

  function automatic logic [6:0] segEncode(digitCode_t code);
    logic [6:0] seg;                            // Active-low segments a..g from MSB to LSB
    seg = 7'b1111111;                           // Blank unless the digit is lit
    if (code.lit) begin
      case (code.value)
        4'h0: seg = 7'b0000001;
        4'h1: seg = 7'b1001111;
        4'h2: seg = 7'b0010010;
        4'h3: seg = 7'b0000110;
        4'h4: seg = 7'b1001100;
        4'h5: seg = 7'b0100100;
        4'h6: seg = 7'b0100000;
        4'h7: seg = 7'b0001111;
        4'h8: seg = 7'b0000000;
        4'h9: seg = 7'b0000100;
        4'hA: seg = 7'b0001000;
        4'hB: seg = 7'b1100000;
        4'hC: seg = 7'b0110001;
        4'hD: seg = 7'b1000010;
        4'hE: seg = 7'b0110000;
        default: seg = 7'b0111000;              // Value F
      endcase
    end
    return seg;
  endfunction

endpackage

// ==== verilog/hexWriteIf.sv ====
interface hexWriteIf;
  import hexDisplayPkg::*;

  logic     wrDigit;                            // Write one digit code at index
  logic     wrBulk;                             // Write all eight values from the bulk view
  logic     wrMask;                             // Write all eight lit flags from word bits 7..0
  logic     rdStrobe;                           // Read request, one cycle wide
  rdKind_t  rdKind;                             // Which register the read targets
  logic [2:0] index;                            // Digit number for single-digit accesses
  hexWord_u word;                               // Registered write data in both views

  modport decoder (
    output wrDigit,
    output wrBulk,
    output wrMask,
    output rdStrobe,
    output rdKind,
    output index,
    output word
  );

  modport store (
    input wrDigit,
    input wrBulk,
    input wrMask,
    input rdStrobe,
    input rdKind,
    input index,
    input word
  );

endinterface

// ==== verilog/hexCmdDecode.sv ====
module hexCmdDecode (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req,   // One-cycle access strobe
  input  logic                            we,    // High for a write, low for a read
  input  logic [hexDisplayPkg::AddrW-1:0] addr,  // Byte address of the access
  input  hexDisplayPkg::hexWord_u         wdata, // Write data, decoded later by the store
  hexWriteIf.decoder                      cmd    // Classified command towards the digit store
);
  import hexDisplayPkg::*;

  logic    aligned;                             // Word-aligned byte address
  logic    hitDigit;                            // Address falls in the digit window
  logic    hitBulk;                             // Address selects the packed values
  logic    hitMask;                             // Address selects the lit flag mask
  logic    isWrite;                             // Write request this cycle
  logic    isRead;                              // Read request this cycle
  rdKind_t kindNext;                            // Read target decoded from the address

  assign aligned  = (addr[1:0] == 2'b00);       // Misaligned accesses count as unmapped
  assign hitDigit = aligned && (addr[AddrW-1:5] == AddrDigitBase[AddrW-1:5]);
  assign hitBulk  = (addr == AddrBulk);
  assign hitMask  = (addr == AddrMask);
  assign isWrite  = req && we;
  assign isRead   = req && !we;

  always_comb begin
    kindNext = RdNone;                          // Anything outside the map reads as zero
    if (hitDigit) begin
      kindNext = RdDigit;
    end else if (hitBulk) begin
      kindNext = RdBulk;
    end else if (hitMask) begin
      kindNext = RdMask;
    end
  end

  // Strobes are one cycle wide and follow the request by exactly one edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd.wrDigit  <= 1'b0;
      cmd.wrBulk   <= 1'b0;
      cmd.wrMask   <= 1'b0;
      cmd.rdStrobe <= 1'b0;
      cmd.rdKind   <= RdNone;
    end else begin
      cmd.wrDigit  <= isWrite && hitDigit;      // Hit flags are exclusive so one strobe at most
      cmd.wrBulk   <= isWrite && hitBulk;
      cmd.wrMask   <= isWrite && hitMask;
      cmd.rdStrobe <= isRead;                   // Unmapped reads still return a zero word
      cmd.rdKind   <= isRead ? kindNext : RdNone;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      cmd.index <= addr[4:2];                   // Digit number inside the digit window
      cmd.word  <= wdata;                       // Only meaningful together with a write strobe
    end
  end

endmodule

// ==== verilog/hexDigitStore.sv ====
module hexDigitStore (
  input  logic                            clk_i,
  input  logic                            rst_i,
  hexWriteIf.store                        cmd,    // Decoded command from the decoder
  output hexDisplayPkg::hexDigits_t       digits, // Current codes of all eight digits
  output logic [hexDisplayPkg::DataW-1:0] rdata,  // Read word, held until the next read
  output logic                            rvalid  // One-cycle pulse with each read word
);
  import hexDisplayPkg::*;

  logic [DataW-1:0]     wordBits;               // Write data seen as a flat vector
  logic [NumDigits-1:0] litMask;                // New lit flags for a mask write
  logic [DataW-1:0]     readWord;               // Read data before the output register

  assign wordBits = cmd.word;
  assign litMask  = wordBits[NumDigits-1:0];    // Bit i controls digit i

  // Write rules for the three write kinds
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      digits <= '0;                             // All digits come up unlit
    end else if (cmd.wrDigit) begin
      digits[cmd.index] <= cmd.word.single.code; // Value and lit flag change together
    end else if (cmd.wrBulk) begin
      for (int i = 0; i < NumDigits; i++) begin
        digits[i].value <= cmd.word.bulk[i];    // Lit flags stay as they are
      end
    end else if (cmd.wrMask) begin
      for (int i = 0; i < NumDigits; i++) begin
        digits[i].lit <= litMask[i];            // Values stay as they are
      end
    end
  end

  // Read word for the requested view of the digit bank
  always_comb begin
    readWord = '0;                              // Upper bits are always zero-filled
    case (cmd.rdKind)
      RdDigit: begin
        readWord[$bits(digitCode_t)-1:0] = digits[cmd.index];
      end
      RdBulk: begin
        for (int i = 0; i < NumDigits; i++) begin
          readWord[4*i +: 4] = digits[i].value; // Same nibble layout as a bulk write
        end
      end
      RdMask: begin
        for (int i = 0; i < NumDigits; i++) begin
          readWord[i] = digits[i].lit;          // Same bit layout as a mask write
        end
      end
      default: begin
        readWord = '0;                          // Unmapped address
      end
    endcase
  end

  // The registers already hold any write from the previous cycle here
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else begin
      rvalid <= cmd.rdStrobe;                   // Two cycles after the bus request
      if (cmd.rdStrobe) begin
        rdata <= readWord;
      end
    end
  end

endmodule

// ==== verilog/hexScanner.sv ====
module hexScanner (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  hexDisplayPkg::hexDigits_t digits,   // Codes of all eight digits from the store
  output logic [6:0]                segments, // Active-low segments of the selected digit
  output logic [7:0]                select    // Active-low digit enables, one low at a time
);
  import hexDisplayPkg::*;

  logic [$clog2(ScanTicks+1)-1:0] scanCnt;      // Cycles spent on the current digit
  logic                           wrap;         // Last cycle of the current digit slot
  logic                           restart;      // Zero bit has left the top of select
  digitCode_t                     selNext;      // Code of the digit selected right now
  digitCode_t                     selCode;      // Registered code, one cycle behind select

  assign wrap    = (scanCnt == ScanTicks);
  assign restart = &select[NumDigits-2:0];      // Also true straight after reset

  // Period counter and the rotating digit select
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scanCnt <= '0;
      select  <= '1;                            // No digit enabled until the first wrap
    end else if (wrap) begin
      scanCnt <= '0;
      // Shift left and feed a zero back in only once the lower seven bits are all ones
      select  <= {select[NumDigits-2:0], !restart};
    end else begin
      scanCnt <= scanCnt + 1'b1;
    end
  end

  // Pick the code whose select bit is low
  always_comb begin
    selNext = '0;                               // Blank while no digit is selected
    for (int i = 0; i < NumDigits; i++) begin
      if (!select[i]) begin
        selNext = digits[i];
      end
    end
  end

  // Two register stages so segments trail a select change by two cycles
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      selCode  <= '0;                           // Unlit code, encodes to a blank digit
      segments <= 7'b1111111;                   // All segments dark
    end else begin
      selCode  <= selNext;
      segments <= segEncode(selCode);           // Shared table with the reference model
    end
  end

endmodule

// ==== verilog/hexDisplayTop.sv ====
module hexDisplayTop (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req,      // One-cycle access strobe
  input  logic                            we,       // High for a write, low for a read
  input  logic [hexDisplayPkg::AddrW-1:0] addr,     // Byte address of the access
  input  logic [hexDisplayPkg::DataW-1:0] wdata,    // Write data
  output logic [hexDisplayPkg::DataW-1:0] rdata,    // Read data, valid with rvalid
  output logic                            rvalid,   // Pulses two cycles after a read request
  output logic [6:0]                      segments, // Active-low segment lines
  output logic [7:0]                      select    // Active-low digit enables
);
  import hexDisplayPkg::*;

  hexDigits_t digits;                           // Stored codes feeding the scanner

  hexWriteIf cmdIf ();                          // Decoder to store command path

  // Decode stage turns bus strobes into typed commands
  hexCmdDecode i_hexCmdDecode (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .cmd   (cmdIf.decoder)
  );

  // Execute stage holds the digit registers and answers reads
  hexDigitStore i_hexDigitStore (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cmd    (cmdIf.store),
    .digits (digits),
    .rdata  (rdata),
    .rvalid (rvalid)
  );

  // Result stage drives the multiplexed display
  hexScanner i_hexScanner (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .digits   (digits),
    .segments (segments),
    .select   (select)
  );

endmodule

// ==== verification/hexScanner_chk.sv ====
module hexScannerChk (
  input logic                                           clk_i,
  input logic                                           rst_i,
  input logic [$clog2(hexDisplayPkg::ScanTicks+1)-1:0] scanCnt,  // Scanner period counter
  input logic [7:0]                                     select,   // Active-low digit enables
  input logic [6:0]                                     segments  // Active-low segments
);
  import hexDisplayPkg::*;

  int failCnt = 0;                              // Read by the testbench at the end of the run

  // Either no digit yet, or exactly one digit enabled
  selOneLow: assert property (@(posedge clk_i) disable iff (rst_i)
    (select == 8'hFF) || ($countones(~select) == 1))
    else begin
      failCnt++;
      $error("select has more than one low bit");
    end

  // The select register moves only on the edge that ends a slot
  selOnWrap: assert property (@(posedge clk_i) disable iff (rst_i)
    (scanCnt != ScanTicks) |=> $stable(select))
    else begin
      failCnt++;
      $error("select changed outside a counter wrap");
    end

  segBlankAfterReset: assert property (@(posedge clk_i)
    rst_i |=> (segments == 7'b1111111))
    else begin
      failCnt++;
      $error("segments not blank right after reset");
    end

endmodule

bind hexScanner hexScannerChk i_hexScannerChk (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .scanCnt  (scanCnt),
  .select   (select),
  .segments (segments)
);

// ==== verification/hexDisplayTb.sv ====
module hexDisplayTb;
  import hexDisplayPkg::*;

  logic             clk_i;
  logic             rst_i;
  logic             req;
  logic             we;
  logic [AddrW-1:0] addr;
  logic [DataW-1:0] wdata;
  logic [DataW-1:0] rdata;
  logic             rvalid;
  logic [6:0]       segments;
  logic [7:0]       select;

  digitCode_t       model [NumDigits];          // Expected contents of the digit registers
  logic [DataW-1:0] pendWord [$];               // Expected words of reads still in flight
  int               pendDue [$];                // Cycle at which each of those reads is due
  int               cycleCnt = 0;               // Rising edges since time zero
  int               errCnt = 0;                 // Mismatches found by the testbench itself
  int               testsRun = 0;
  int               testsFailed = 0;

  hexDisplayTop i_hexDisplayTop (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req      (req),
    .we       (we),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .segments (segments),
    .select   (select)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;                  // Period of 8 time units
  end

  // Six full scan frames plus headroom for the bus tests
  always @(posedge clk_i) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= 6 * (ScanTicks + 1) * NumDigits + 2000) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleCnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic int totalErrors();
    return errCnt + i_hexDisplayTop.i_hexScanner.i_hexScannerChk.failCnt; // Assertions too
  endfunction

  function automatic bit isMapped(logic [AddrW-1:0] a);
    return (a[1:0] == 2'b00 && a < 6'h20) || a == 6'h20 || a == 6'h24;
  endfunction

  function automatic logic [AddrW-1:0] randUnmapped();
    logic [31:0]      r;
    logic [AddrW-1:0] a;
    a = 6'h20;
    while (isMapped(a)) begin
      r = $urandom();
      a = r[AddrW-1:0];                         // Misaligned digit addresses qualify too
    end
    return a;
  endfunction

  // Register map as software sees it
  function automatic void modelWrite(logic [AddrW-1:0] a, logic [DataW-1:0] d);
    if (a[1:0] == 2'b00 && a < 6'h20) begin
      model[a[4:2]] = d[4:0];                   // Lit flag in bit 4, value below it
    end else if (a == 6'h20) begin
      for (int i = 0; i < NumDigits; i++) begin
        model[i].value = d[4*i +: 4];
      end
    end else if (a == 6'h24) begin
      for (int i = 0; i < NumDigits; i++) begin
        model[i].lit = d[i];
      end
    end
  endfunction

  function automatic logic [DataW-1:0] modelRead(logic [AddrW-1:0] a);
    logic [DataW-1:0] w;
    w = '0;
    if (a[1:0] == 2'b00 && a < 6'h20) begin
      w[4:0] = model[a[4:2]];
    end else if (a == 6'h20) begin
      for (int i = 0; i < NumDigits; i++) begin
        w[4*i +: 4] = model[i].value;
      end
    end else if (a == 6'h24) begin
      for (int i = 0; i < NumDigits; i++) begin
        w[i] = model[i].lit;
      end
    end
    return w;
  endfunction

  task automatic checkWord(string name, logic [DataW-1:0] got, logic [DataW-1:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkSeg(string name, logic [6:0] got, logic [6:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
      errCnt++;
    end
  endtask

  task automatic checkSel(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s = %b, expected %b", $time, name, got, exp);
      errCnt++;
    end
  endtask

  // Matches rvalid against the oldest outstanding read
  task automatic collectRead();
    int               due;
    logic [DataW-1:0] exp;
    if (rvalid === 1'b1) begin
      if (pendDue.size() == 0) begin
        $display("At time %0t rvalid went high although no read was pending", $time);
        errCnt++;
      end else begin
        due = pendDue.pop_front();
        exp = pendWord.pop_front();
        if (due != cycleCnt) begin
          $display("At time %0t a read came back at cycle %0d instead of cycle %0d",
                   $time, cycleCnt, due);
          errCnt++;
        end
        checkWord("rdata", rdata, exp);
      end
    end else if (pendDue.size() > 0 && pendDue[0] <= cycleCnt) begin
      $display("At time %0t rvalid never came for the read due at cycle %0d", $time, pendDue[0]);
      errCnt++;
      void'(pendDue.pop_front());
      void'(pendWord.pop_front());
    end
  endtask

  // One bus cycle, driven on the falling edge
  task automatic busCycle(logic r, logic w, logic [AddrW-1:0] a, logic [DataW-1:0] d);
    @(negedge clk_i);
    collectRead();
    req   = r;
    we    = w;
    addr  = a;
    wdata = d;
    if (r && w) begin
      modelWrite(a, d);                         // Reads from the next cycle on see this write
    end else if (r) begin
      pendWord.push_back(modelRead(a));
      pendDue.push_back(cycleCnt + 2);          // Two cycles of read latency
    end
  endtask

  task automatic idleCycles(int n);
    repeat (n) busCycle(1'b0, 1'b0, '0, '0);
  endtask

  task automatic finishTest(string name, int errBefore);
    int n;
    n = totalErrors() - errBefore;
    testsRun++;
    if (n == 0) begin
      $display("Test %0d %s: passed", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: failed with %0d errors", testsRun, name, n);
    end
  endtask

  // Waits for select to move, or for slot 0 to begin when firstSlot is set
  task automatic waitSelChange(bit firstSlot, output bit ok);
    logic [7:0] prevSel;
    prevSel = select;
    ok = 1'b0;
    for (int n = 0; n < 2 * (ScanTicks + 1) * NumDigits && !ok; n++) begin
      @(negedge clk_i);
      if (select !== prevSel && (!firstSlot || select === 8'hFE)) ok = 1'b1;
      prevSel = select;
    end
  endtask

  initial begin
    logic [31:0]      r;
    logic [DataW-1:0] d;
    logic [7:0]       expSel;
    logic [2:0]       idx;
    bit               ok;
    int               errBefore;
    void'($urandom(32'ha516));
    rst_i = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    for (int i = 0; i < NumDigits; i++) model[i] = '0;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;

    errBefore = totalErrors();
    checkSel("select", select, 8'hFF);
    checkSeg("segments", segments, 7'b1111111);
    idleCycles(20);                             // Any rvalid here is flagged by collectRead
    finishTest("reset state", errBefore);

    errBefore = totalErrors();
    for (int k = 0; k < 40; k++) begin
      r = $urandom();
      d = $urandom();
      d[4:0] = r[8:4];                          // Upper data bits are random noise
      busCycle(1'b1, 1'b1, {1'b0, r[2:0], 2'b00}, d);
      if (r[9]) begin
        idx = r[10] ? r[2:0] : r[13:11];        // Often the digit just written
        busCycle(1'b1, 1'b0, {1'b0, idx, 2'b00}, '0);
      end
    end
    idleCycles(4);
    finishTest("single-digit writes", errBefore);

    errBefore = totalErrors();
    for (int k = 0; k < 12; k++) begin
      r = $urandom();
      d = $urandom();
      busCycle(1'b1, 1'b1, r[0] ? 6'h20 : 6'h24, d);
      busCycle(1'b1, 1'b0, 6'h20, '0);
      busCycle(1'b1, 1'b0, 6'h24, '0);
      for (int i = 0; i < NumDigits; i++) begin
        idx = i[2:0];
        busCycle(1'b1, 1'b0, {1'b0, idx, 2'b00}, '0);
      end
    end
    idleCycles(4);
    finishTest("bulk and mask writes", errBefore);

    errBefore = totalErrors();
    for (int k = 0; k < 20; k++) begin
      busCycle(1'b1, 1'b0, randUnmapped(), '0);
    end
    for (int k = 0; k < 20; k++) begin
      busCycle(1'b1, 1'b1, randUnmapped(), $urandom());
    end
    busCycle(1'b1, 1'b0, 6'h20, '0);
    busCycle(1'b1, 1'b0, 6'h24, '0);
    for (int i = 0; i < NumDigits; i++) begin
      idx = i[2:0];
      busCycle(1'b1, 1'b0, {1'b0, idx, 2'b00}, '0);
    end
    idleCycles(4);
    finishTest("unmapped addresses", errBefore);

    errBefore = totalErrors();
    for (int i = 0; i < NumDigits; i++) begin
      idx = i[2:0];
      busCycle(1'b1, 1'b1, {1'b0, idx, 2'b00}, $urandom());
    end
    idleCycles(4);
    waitSelChange(1'b1, ok);
    if (!ok) begin
      $display("At time %0t the scan never reached digit 0", $time);
      errCnt++;
    end else begin
      for (int f = 0; f < 2; f++) begin
        for (int i = 0; i < NumDigits; i++) begin
          if (f != 0 || i != 0) waitSelChange(1'b0, ok);
          if (!ok) begin
            $display("At time %0t select stopped advancing", $time);
            errCnt++;
          end
          repeat (ScanTicks) @(negedge clk_i);  // Last cycle of the slot
          expSel = 8'hFF;
          expSel[i] = 1'b0;
          checkSel("select", select, expSel);
          checkSeg("segments", segments, segEncode(model[i]));
        end
      end
    end
    finishTest("scan output", errBefore);

    $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, totalErrors());
    if (totalErrors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
verilog/hexDisplayPkg.sv
verilog/hexWriteIf.sv
verilog/hexCmdDecode.sv
verilog/hexDigitStore.sv
verilog/hexScanner.sv
verilog/hexDisplayTop.sv
verification/hexScanner_chk.sv
verification/hexDisplayTb.sv

// ==== Bender.yml ====
package:
  name: hex_display

sources:
  # Design sources in compile order
  - verilog/hexDisplayPkg.sv
  - verilog/hexWriteIf.sv
  - verilog/hexCmdDecode.sv
  - verilog/hexDigitStore.sv
  - verilog/hexScanner.sv
  - verilog/hexDisplayTop.sv

  # Verification sources
  - target: test
    files:
      - verification/hexScanner_chk.sv
      - verification/hexDisplayTb.sv
